/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cache_subsystem
FLIST ?= sources.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_sram.sv
verilog/cache.sv
verilog/mem_arbiter.sv
verilog/cache_subsystem.sv
tests/cache_subsystem_sva.sv
tests/tb_cache_subsystem.sv

/* tests/cache_subsystem_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem_sva (
    input logic clk,
    input logic rst,
    input cache_pkg::dfp_req_t i_req,
    input cache_pkg::dfp_req_t d_req,
    input logic mem_resp,
    input logic i_resp,
    input logic d_resp,
    input cache_pkg::dfp_req_t mem_req
);

    int failures = 0;

    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write))
        else begin
            $error("memory read and write strobes are high together");
            failures++;
        end

    // granted request holds until memory answers
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) && !mem_resp |=> $stable(mem_req))
        else begin
            $error("memory request changed before its response");
            failures++;
        end

    // each memory response reaches exactly one cache
    a_resp_excl: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (i_resp ^ d_resp))
        else begin
            $error("memory response did not go to exactly one cache");
            failures++;
        end

    a_i_resp_src: assert property (@(posedge clk) disable iff (rst)
        i_resp |-> (i_req.read || i_req.write))
        else begin
            $error("instruction cache response without its strobe");
            failures++;
        end

    a_d_resp_src: assert property (@(posedge clk) disable iff (rst)
        d_resp |-> (d_req.read || d_req.write))
        else begin
            $error("data cache response without its strobe");
            failures++;
        end

endmodule

`default_nettype wire

/* tests/tb_cache_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;

    import cache_pkg::*;

    localparam int TIMEOUT = 400;
    localparam word_t FILL_KEY = 32'h3c5a_c0de;

    logic clk;
    logic rst;
    ufp_req_t imem;
    ufp_req_t dmem;
    word_t imem_rdata;
    word_t dmem_rdata;
    logic imem_resp;
    logic dmem_resp;
    dfp_req_t mem;
    line_t mem_rdata;
    logic mem_resp;

    int errors;
    int timeouts;
    int mem_reads;
    int mem_writes;
    addr_t last_read_addr;
    logic pending;
    int delay;
    dfp_req_t held;

    line_t mem_lines [addr_t];
    logic [7:0] shadow [addr_t];

    cache_subsystem i_dut (.*);

    bind mem_arbiter cache_subsystem_sva u_sva (.*);

    // untouched memory, each word is its byte address xor a key
    function automatic word_t addr_word(addr_t a);
        return {a[31:2], 2'b00} ^ FILL_KEY;
    endfunction

    function automatic line_t read_line(addr_t base);
        line_t line;
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end
        for (int w = 0; w < 8; w++) begin
            line[32 * w +: 32] = addr_word(base + addr_t'(4 * w));
        end
        return line;
    endfunction

    function automatic word_t expected_word(addr_t a);
        word_t exp;
        addr_t byte_addr;
        exp = addr_word(a);
        for (int b = 0; b < 4; b++) begin
            byte_addr = {a[31:2], 2'b00} + addr_t'(b);
            if (shadow.exists(byte_addr)) begin
                exp[8 * b +: 8] = shadow[byte_addr];
            end
        end
        return exp;
    endfunction

    // separate regions keep the two caches off each other's lines
    function automatic addr_t region(int port);
        return (port != 0) ? 32'h0008_0000 : 32'h0001_0000;
    endfunction

    task automatic check_true(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t %s", $time, what);
        end
    endtask

    // one load (wmask zero) or store, cycles counts the wait for resp
    task automatic access(input int port, input addr_t addr, input mask_t wmask,
                          input word_t wdata, output int cycles);
        ufp_req_t req;
        word_t got;
        word_t exp;
        logic seen;
        req.addr = addr;
        req.rmask = (wmask == '0) ? 4'hf : 4'h0;
        req.wmask = wmask;
        req.wdata = wdata;
        seen = 1'b0;
        cycles = 0;
        @(posedge clk);
        if (port != 0) begin
            dmem <= req;
        end else begin
            imem <= req;
        end
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            seen = (port != 0) ? dmem_resp : imem_resp;
            got = (port != 0) ? dmem_rdata : imem_rdata;
            if (!seen) begin
                cycles++;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("port %0d got no response for address %h in %0d cycles", port, addr,
                     TIMEOUT);
        end else if (wmask == '0) begin
            exp = expected_word(addr);
            assert (got == exp) else begin
                errors++;
                $display("[FAIL] %0t port %0d load %h returned %h, expected %h", $time, port,
                         addr, got, exp);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    shadow[{addr[31:2], 2'b00} + addr_t'(b)] = wdata[8 * b +: 8];
                end
            end
        end
        @(posedge clk);
        if (port != 0) begin
            dmem <= '0;
        end else begin
            imem <= '0;
        end
    endtask

    task automatic random_traffic(input int port);
        int cycles;
        addr_t a;
        mask_t wmask;
        for (int n = 0; n < 60; n++) begin
            a = region(port) + addr_t'($urandom_range(5, 0) << 9)
                + addr_t'($urandom_range(2, 0) << 5) + addr_t'($urandom_range(7, 0) << 2);
            wmask = ($urandom_range(1, 0) == 1) ? mask_t'($urandom_range(15, 1)) : 4'h0;
            access(port, a, wmask, $urandom, cycles);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // memory model, takes a strobe mid-cycle and answers 1 to 8 edges later
    initial begin
        mem_resp = 1'b0;
        mem_rdata = '0;
        pending = 1'b0;
        delay = 0;
        mem_reads = 0;
        mem_writes = 0;
        last_read_addr = '0;
        forever begin
            @(negedge clk);
            if (!rst && !pending && !mem_resp && (mem.read || mem.write)) begin
                pending = 1'b1;
                delay = $urandom_range(8, 1);
                held = mem;
            end
            @(posedge clk);
            if (mem_resp) begin
                mem_resp <= 1'b0;
            end else if (pending && delay > 1) begin
                delay--;
            end else if (pending) begin
                pending = 1'b0;
                mem_resp <= 1'b1;
                if (held.write) begin
                    mem_lines[held.addr] = held.wdata;
                    mem_writes++;
                end else begin
                    mem_rdata <= read_line(held.addr);
                    mem_reads++;
                    last_read_addr = held.addr;
                end
            end
        end
    end

    initial begin
        int cycles;
        int reads_before;
        int writes_before;
        int sva_failures;
        addr_t a;
        void'($urandom(46016));
        errors = 0;
        timeouts = 0;
        rst = 1'b1;
        imem = '0;
        dmem = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int p = 0; p < 2; p++) begin
            a = region(p) + 32'h0000_00e4;
            reads_before = mem_reads;
            access(p, a, 4'h0, '0, cycles);
            check_true(mem_reads == reads_before + 1, "cold read did not fetch exactly one line");
            check_true(last_read_addr == {a[31:5], 5'b0}, "cold read fetched the wrong line");
        end

        // partial store, then the load must hit
        for (int p = 0; p < 2; p++) begin
            a = region(p) + 32'h0000_0108;
            access(p, a, 4'b0110, 32'ha1b2_c3d4, cycles);
            access(p, a, 4'h0, '0, cycles);
            check_true(cycles == 1, "load after store was not a one cycle hit");
        end

        writes_before = mem_writes;
        for (int t = 0; t < 5; t++) begin
            access(1, region(1) + addr_t'(t << 9) + 32'h64, 4'hf, 32'h5500_0000 + word_t'(t),
                   cycles);
        end
        check_true(mem_writes > writes_before, "five tags in one set caused no writeback");
        access(1, region(1) + 32'h64, 4'h0, '0, cycles);

        fork
            random_traffic(0);
            random_traffic(1);
        join

        repeat (5) @(posedge clk);
        sva_failures = i_dut.u_arbiter.u_sva.failures;
        $display("errors: %0d  timeouts: %0d  assertion failures: %0d", errors, timeouts,
                 sva_failures);
        if (errors == 0 && timeouts == 0 && sva_failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache (
    input logic clk,
    input logic rst,
    input cache_pkg::ufp_req_t ufp,
    output cache_pkg::word_t ufp_rdata,
    output logic ufp_resp,
    output cache_pkg::dfp_req_t dfp,
    input cache_pkg::line_t dfp_rdata,
    input logic dfp_resp
);

    import cache_pkg::*;

    cache_state_t state;
    cache_state_t next_state;

    ufp_req_t req;
    line_t fill_line;

    tag_t tag_out [`CACHE_WAYS];
    line_t data_out [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_out;
    logic [`CACHE_WAYS-1:0] dirty_out;
    plru_t plru_out;

    set_t arr_set;
    tag_t req_tag;
    set_t req_set;
    logic [`OFFSET_BITS-3:0] word_sel;

    logic hit;
    way_t hit_way;
    way_t victim;
    logic is_store;

    logic [`CACHE_WAYS-1:0] fill_we;
    logic [`CACHE_WAYS-1:0] data_we;
    logic [`CACHE_WAYS-1:0] dirty_we;
    logic plru_we;
    line_t data_din;
    logic dirty_din;
    plru_t plru_din;

    // overwrite the enabled bytes of one word in a line
    function automatic line_t merge_word(line_t line, logic [`OFFSET_BITS-3:0] sel,
                                         word_t data, mask_t mask);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[32 * sel + 8 * b +: 8] = data[8 * b +: 8];
            end
        end
        return merged;
    endfunction

    // point the tree away from the way just used
    function automatic plru_t plru_touch(plru_t cur, way_t w);
        plru_t nxt;
        nxt = cur;
        nxt[2] = w[1];
        if (w[1]) begin
            nxt[0] = w[0];
        end else begin
            nxt[1] = w[0];
        end
        return nxt;
    endfunction

    assign req_tag = req.addr[31 -: `TAG_BITS];
    assign req_set = req.addr[`OFFSET_BITS +: `SET_BITS];
    assign word_sel = req.addr[`OFFSET_BITS-1:2];
    assign is_store = |req.wmask;

    // idle looks up the incoming set so compare sees its tags
    assign arr_set = (state == idle) ? ufp.addr[`OFFSET_BITS +: `SET_BITS] : req_set;

    generate
        for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
            cache_sram #(.WIDTH(`TAG_BITS)) u_tag (
                .clk(clk),
                .rst(rst),
                .we(fill_we[w]),
                .addr(arr_set),
                .din(req_tag),
                .dout(tag_out[w])
            );

            cache_sram #(.WIDTH(`LINE_BITS)) u_data (
                .clk(clk),
                .rst(rst),
                .we(data_we[w]),
                .addr(arr_set),
                .din(data_din),
                .dout(data_out[w])
            );

            cache_sram #(.WIDTH(1), .RESET_EN(1'b1)) u_valid (
                .clk(clk),
                .rst(rst),
                .we(fill_we[w]),
                .addr(arr_set),
                .din(1'b1),
                .dout(valid_out[w])
            );

            cache_sram #(.WIDTH(1), .RESET_EN(1'b1)) u_dirty (
                .clk(clk),
                .rst(rst),
                .we(dirty_we[w]),
                .addr(arr_set),
                .din(dirty_din),
                .dout(dirty_out[w])
            );
        end
    endgenerate

    cache_sram #(.WIDTH($bits(plru_t)), .RESET_EN(1'b1)) u_plru (
        .clk(clk),
        .rst(rst),
        .we(plru_we),
        .addr(arr_set),
        .din(plru_din),
        .dout(plru_out)
    );

    // lowest matching way wins
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!hit && valid_out[w] && (tag_out[w] == req_tag)) begin
                hit = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        if (plru_out[2]) begin
            victim = {1'b0, ~plru_out[1]};
        end else begin
            victim = {1'b1, ~plru_out[0]};
        end
    end

    assign ufp_rdata = (state == respond) ? fill_line[32 * word_sel +: 32]
                                          : data_out[hit_way][32 * word_sel +: 32];

    always_comb begin
        next_state = state;
        ufp_resp = 1'b0;
        dfp = '0;
        fill_we = '0;
        data_we = '0;
        dirty_we = '0;
        plru_we = 1'b0;
        data_din = merge_word(data_out[hit_way], word_sel, req.wdata, req.wmask);
        dirty_din = 1'b1;
        plru_din = plru_touch(plru_out, hit_way);

        case (state)
            idle: begin
                if ((|ufp.rmask) || (|ufp.wmask)) begin
                    next_state = compare;
                end
            end
            compare: begin
                if (hit) begin
                    ufp_resp = 1'b1;
                    plru_we = 1'b1;
                    data_we[hit_way] = is_store;
                    dirty_we[hit_way] = is_store;
                    next_state = idle;
                end else if (valid_out[victim] && dirty_out[victim]) begin
                    next_state = writeback;
                end else begin
                    next_state = allocate;
                end
            end
            writeback: begin
                dfp.write = 1'b1;
                dfp.addr = {tag_out[victim], req_set, {`OFFSET_BITS{1'b0}}};
                dfp.wdata = data_out[victim];
                if (dfp_resp) begin
                    next_state = allocate;
                end
            end
            allocate: begin
                dfp.read = 1'b1;
                dfp.addr = {req_tag, req_set, {`OFFSET_BITS{1'b0}}};
                if (dfp_resp) begin
                    next_state = fill;
                end
            end
            fill: begin
                // install the new line with the pending store already merged
                fill_we[victim] = 1'b1;
                data_we[victim] = 1'b1;
                dirty_we[victim] = 1'b1;
                plru_we = 1'b1;
                data_din = merge_word(fill_line, word_sel, req.wdata, req.wmask);
                dirty_din = is_store;
                plru_din = plru_touch(plru_out, victim);
                next_state = respond;
            end
            respond: begin
                ufp_resp = 1'b1;
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle) begin
            req <= ufp;
        end
        if ((state == allocate) && dfp_resp) begin
            fill_line <= dfp_rdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16

// address split: tag | set | byte offset
`define SET_BITS 4
`define OFFSET_BITS 5
`define TAG_BITS 23

// one line is 8 words
`define LINE_BITS 256

`endif

/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

`include "cache_defs.svh"

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] mask_t;
    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] set_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [`CACHE_WAYS-2:0] plru_t;

    // core side request, masks held nonzero until resp
    typedef struct packed {
        addr_t addr;
        mask_t rmask;
        mask_t wmask;
        word_t wdata;
    } ufp_req_t;

    // memory side request, read and write are levels
    typedef struct packed {
        addr_t addr;
        logic read;
        logic write;
        line_t wdata;
    } dfp_req_t;

    typedef enum logic [2:0] {
        idle,
        compare,
        writeback,
        allocate,
        fill,
        respond
    } cache_state_t;

endpackage

`default_nettype wire

/* verilog/cache_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_sram #(
    parameter int WIDTH = 1,
    parameter bit RESET_EN = 1'b0
) (
    input logic clk,
    input logic rst,
    input logic we,
    input cache_pkg::set_t addr,
    input logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] mem [`CACHE_SETS];

    // registered read, a write in the same cycle shows up one access later
    always_ff @(posedge clk) begin
        if (RESET_EN && rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
    input logic clk,
    input logic rst,

    input cache_pkg::ufp_req_t imem,
    output cache_pkg::word_t imem_rdata,
    output logic imem_resp,

    input cache_pkg::ufp_req_t dmem,
    output cache_pkg::word_t dmem_rdata,
    output logic dmem_resp,

    output cache_pkg::dfp_req_t mem,
    input cache_pkg::line_t mem_rdata,
    input logic mem_resp
);

    import cache_pkg::*;

    dfp_req_t i_dfp;
    dfp_req_t d_dfp;
    logic i_dfp_resp;
    logic d_dfp_resp;

    cache i_cache (
        .clk(clk),
        .rst(rst),
        .ufp(imem),
        .ufp_rdata(imem_rdata),
        .ufp_resp(imem_resp),
        .dfp(i_dfp),
        .dfp_rdata(mem_rdata),
        .dfp_resp(i_dfp_resp)
    );

    cache d_cache (
        .clk(clk),
        .rst(rst),
        .ufp(dmem),
        .ufp_rdata(dmem_rdata),
        .ufp_resp(dmem_resp),
        .dfp(d_dfp),
        .dfp_rdata(mem_rdata),
        .dfp_resp(d_dfp_resp)
    );

    // both caches see the line data, only the granted one gets resp
    mem_arbiter u_arbiter (
        .clk(clk),
        .rst(rst),
        .i_req(i_dfp),
        .d_req(d_dfp),
        .mem_resp(mem_resp),
        .i_resp(i_dfp_resp),
        .d_resp(d_dfp_resp),
        .mem_req(mem)
    );

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input logic clk,
    input logic rst,
    input cache_pkg::dfp_req_t i_req,
    input cache_pkg::dfp_req_t d_req,
    input logic mem_resp,
    output logic i_resp,
    output logic d_resp,
    output cache_pkg::dfp_req_t mem_req
);

    logic busy;
    // 0 selects the instruction side, 1 the data side
    logic owner;
    logic prio;
    logic sel;
    logic active;
    logic i_strobe;
    logic d_strobe;

    assign i_strobe = i_req.read | i_req.write;
    assign d_strobe = d_req.read | d_req.write;
    assign active = busy | i_strobe | d_strobe;

    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (i_strobe && d_strobe) begin
            sel = prio;
        end else begin
            sel = d_strobe;
        end
    end

    // granted request goes straight through, no added cycle
    assign mem_req = sel ? d_req : i_req;
    assign i_resp = mem_resp & active & ~sel;
    assign d_resp = mem_resp & active & sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            owner <= 1'b0;
            prio <= 1'b0;
        end else if (mem_resp && active) begin
            busy <= 1'b0;
            // side just served drops to low priority
            prio <= ~sel;
        end else if (!busy && active) begin
            busy <= 1'b1;
            owner <= sel;
        end
    end

endmodule

`default_nettype wire
